//--- common/bp_bus_pkg.sv
// ----------------------------------------------------------------------
// wishbone field widths and address layout, opcode enum
// command, prediction, update and statistics structs
// ----------------------------------------------------------------------
`default_nettype none

package bp_bus_pkg;

  localparam int wb_adr_w = 6;   // byte-free word address
  localparam int wb_dat_w = 32;
  localparam int stat_w   = 16;  // each statistics counter

  // address layout, op in 5:4, line in 3:2, slot in 1:0
  localparam int adr_slot_lsb = 0;
  localparam int adr_line_lsb = 2;
  localparam int adr_op_lsb   = 4;

  // opcodes, predict and stats are reads, resolve and clear are writes
  typedef enum logic [1:0] {
    op_predict = 2'd0,
    op_resolve = 2'd1,  // dat_w[0] is the outcome
    op_stats   = 2'd2,
    op_clear   = 2'd3
  } bp_op_e;

  // one accepted bus cycle
  typedef struct packed {
    logic                             valid;
    bp_op_e                           op;
    logic [bp_cfg_pkg::bp_line_w-1:0] line;
    logic [bp_cfg_pkg::bp_slot_w-1:0] slot;
    logic                             taken;  // resolve outcome
  } bp_cmd_t;

  // taken bit per slot of the addressed line
  typedef struct packed {
    logic [bp_cfg_pkg::bp_slots-1:0] taken;
  } bp_pred_t;

  // resolve event toward the statistics
  typedef struct packed {
    logic valid;
    logic pred_taken;  // counter's prediction before the step
    logic outcome;
  } bp_update_t;

  // read back as one word
  typedef struct packed {
    logic [stat_w-1:0] mispredicts;
    logic [stat_w-1:0] resolves;
  } bp_stats_t;

endpackage

`default_nettype wire

//--- common/bp_cfg_pkg.sv
// ----------------------------------------------------------------------
// predictor geometry localparams
// 2-bit counter state enum and its reset value
// ----------------------------------------------------------------------
`default_nettype none

package bp_cfg_pkg;

  // table shape, one counter per slot of a four-wide fetch group
  localparam int bp_lines  = 4;  // lines in the table
  localparam int bp_line_w = 2;  // line index width
  localparam int bp_slots  = 4;  // counters per line
  localparam int bp_slot_w = 2;  // slot index width

  // saturating counter states
  // upper bit is the taken prediction, so the order matters
  typedef enum logic [1:0] {
    strong_nt = 2'd0,
    weak_nt   = 2'd1,
    weak_t    = 2'd2,
    strong_t  = 2'd3
  } bp_ctr_e;

  // value after reset and after a clear command
  localparam bp_ctr_e bp_ctr_reset = weak_nt;

endpackage

`default_nettype wire

//--- design/bp_top.sv
// ----------------------------------------------------------------------
// branch prediction buffer top level
// wishbone front end, counter table and result block
// ----------------------------------------------------------------------
`default_nettype none

module bp_top (
  input  wire logic                             clock,
  input  wire logic                             rst_n,
  // wishbone classic slave
  input  wire logic                             cyc,
  input  wire logic                             stb,
  input  wire logic                             we,
  input  wire logic [bp_bus_pkg::wb_adr_w-1:0]  adr,
  input  wire logic [bp_bus_pkg::wb_dat_w-1:0]  dat_w,
  output logic                                  ack,
  output logic      [bp_bus_pkg::wb_dat_w-1:0]  dat_r
);

  bp_bus_pkg::bp_cmd_t    cmd;   // registered command, valid with ack
  bp_bus_pkg::bp_pred_t   pred;  // taken bits of cmd.line
  bp_bus_pkg::bp_update_t upd;   // resolve toward statistics

  // decode stage
  bp_wb_decode u_decode (
    .clock (clock),
    .rst_n (rst_n),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .ack   (ack),
    .cmd   (cmd)
  );

  // execute stage, the counter table
  bp_counter_banks u_banks (
    .clock (clock),
    .rst_n (rst_n),
    .cmd   (cmd),
    .pred  (pred),
    .upd   (upd)
  );

  // result stage, stats and read data
  bp_result u_result (
    .clock (clock),
    .rst_n (rst_n),
    .cmd   (cmd),
    .pred  (pred),
    .upd   (upd),
    .dat_r (dat_r)
  );

endmodule

`default_nettype wire

//--- filelist.f
+incdir+tb
common/bp_cfg_pkg.sv
common/bp_bus_pkg.sv
predictor/bp_wb_decode.sv
predictor/bp_counter_banks.sv
predictor/bp_result.sv
design/bp_top.sv
tb/bp_tb.sv

//--- predictor/bp_counter_banks.sv
// ----------------------------------------------------------------------
// four banks of 2-bit saturating counters, one bank per slot
// line lookup, single-counter update and table clear
// ----------------------------------------------------------------------
`default_nettype none

module bp_counter_banks (
  input  wire logic               clock,
  input  wire logic               rst_n,
  input  wire bp_bus_pkg::bp_cmd_t cmd,
  output bp_bus_pkg::bp_pred_t    pred,
  output bp_bus_pkg::bp_update_t  upd
);

  // ctr_q[slot][line]
  bp_cfg_pkg::bp_ctr_e ctr_q [bp_cfg_pkg::bp_slots][bp_cfg_pkg::bp_lines];

  bp_cfg_pkg::bp_ctr_e ctr_sel;     // addressed counter
  logic                resolve_en;
  logic                clear_en;

  // upper half of the range predicts taken
  function automatic logic ctr_taken(input bp_cfg_pkg::bp_ctr_e c);
    return (c == bp_cfg_pkg::weak_t) || (c == bp_cfg_pkg::strong_t);
  endfunction

  // one step toward strong_t on taken, toward strong_nt otherwise
  function automatic bp_cfg_pkg::bp_ctr_e ctr_step(input bp_cfg_pkg::bp_ctr_e c,
                                                   input logic taken);
    bp_cfg_pkg::bp_ctr_e n;
    case (c)
      bp_cfg_pkg::strong_nt: n = taken ? bp_cfg_pkg::weak_nt  : bp_cfg_pkg::strong_nt;
      bp_cfg_pkg::weak_nt:   n = taken ? bp_cfg_pkg::weak_t   : bp_cfg_pkg::strong_nt;
      bp_cfg_pkg::weak_t:    n = taken ? bp_cfg_pkg::strong_t : bp_cfg_pkg::weak_nt;
      default:               n = taken ? bp_cfg_pkg::strong_t : bp_cfg_pkg::weak_t;
    endcase
    return n;
  endfunction

  assign resolve_en = cmd.valid && (cmd.op == bp_bus_pkg::op_resolve);
  assign clear_en   = cmd.valid && (cmd.op == bp_bus_pkg::op_clear);

  assign ctr_sel = ctr_q[cmd.slot][cmd.line];

  // lookup, straight from the current counters
  always_comb begin
    for (int s = 0; s < bp_cfg_pkg::bp_slots; s++) begin
      pred.taken[s] = ctr_taken(ctr_q[s][cmd.line]);
    end
  end

  // prediction before the step, for mispredict counting
  always_comb begin
    upd.valid      = resolve_en;
    upd.pred_taken = ctr_taken(ctr_sel);
    upd.outcome    = cmd.taken;
  end

  // written at the edge closing the ack cycle
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < bp_cfg_pkg::bp_slots; s++) begin
        for (int l = 0; l < bp_cfg_pkg::bp_lines; l++) begin
          ctr_q[s][l] <= bp_cfg_pkg::bp_ctr_reset;  // weak not taken
        end
      end
    end else if (clear_en) begin
      // whole table back to its reset state
      for (int s = 0; s < bp_cfg_pkg::bp_slots; s++) begin
        for (int l = 0; l < bp_cfg_pkg::bp_lines; l++) begin
          ctr_q[s][l] <= bp_cfg_pkg::bp_ctr_reset;
        end
      end
    end else if (resolve_en) begin
      ctr_q[cmd.slot][cmd.line] <= ctr_step(ctr_sel, cmd.taken);  // saturates at both ends
    end
  end

endmodule

`default_nettype wire

//--- predictor/bp_result.sv
// ----------------------------------------------------------------------
// resolve and mispredict counters
// read data select by opcode
// ----------------------------------------------------------------------
`default_nettype none

module bp_result (
  input  wire logic                           clock,
  input  wire logic                           rst_n,
  input  wire bp_bus_pkg::bp_cmd_t            cmd,
  input  wire bp_bus_pkg::bp_pred_t           pred,
  input  wire bp_bus_pkg::bp_update_t         upd,
  output logic [bp_bus_pkg::wb_dat_w-1:0]     dat_r
);

  bp_bus_pkg::bp_stats_t stats_q;
  logic                  mispredict;
  logic                  clear_en;

  assign mispredict = upd.pred_taken != upd.outcome;
  assign clear_en   = cmd.valid && (cmd.op == bp_bus_pkg::op_clear);

  // both counts wrap at stat_w bits
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      stats_q <= '0;
    end else if (clear_en) begin
      stats_q <= '0;
    end else if (upd.valid) begin
      stats_q.resolves <= stats_q.resolves + 1'b1;
      if (mispredict) begin
        stats_q.mispredicts <= stats_q.mispredicts + 1'b1;
      end
    end
  end

  // read data, zero unless a legal read is being acked
  always_comb begin
    dat_r = '0;
    if (cmd.valid) begin
      case (cmd.op)
        bp_bus_pkg::op_predict: dat_r = bp_bus_pkg::wb_dat_w'(pred);  // zero-extended
        bp_bus_pkg::op_stats:   dat_r = stats_q;
        default:                dat_r = '0;  // writes return nothing
      endcase
    end
  end

endmodule

`default_nettype wire

//--- predictor/bp_wb_decode.sv
// ----------------------------------------------------------------------
// wishbone classic slave front end
// registers each accepted cycle into a command and a one-cycle ack
// ----------------------------------------------------------------------
`default_nettype none

module bp_wb_decode (
  input  wire logic                             clock,
  input  wire logic                             rst_n,
  input  wire logic                             cyc,
  input  wire logic                             stb,
  input  wire logic                             we,
  input  wire logic [bp_bus_pkg::wb_adr_w-1:0]  adr,
  input  wire logic [bp_bus_pkg::wb_dat_w-1:0]  dat_w,
  output logic                                  ack,
  output bp_bus_pkg::bp_cmd_t                   cmd
);

  bp_bus_pkg::bp_op_e                   req_op;
  logic                                 op_is_write;
  logic                                 accept;
  logic                                 legal;

  // command registers
  logic                                 valid_q;
  bp_bus_pkg::bp_op_e                   op_q;
  logic [bp_cfg_pkg::bp_line_w-1:0]     line_q;
  logic [bp_cfg_pkg::bp_slot_w-1:0]     slot_q;
  logic                                 taken_q;

  assign req_op = bp_bus_pkg::bp_op_e'(adr[bp_bus_pkg::adr_op_lsb +: $bits(bp_bus_pkg::bp_op_e)]);
  assign op_is_write = (req_op == bp_bus_pkg::op_resolve) ||
                       (req_op == bp_bus_pkg::op_clear);

  // new request only while no ack is out, master holds stb until it sees ack
  assign accept = cyc && stb && !ack;
  // direction must agree with the opcode, otherwise ack with no effect
  assign legal  = (we == op_is_write);

  // control, one ack per bus cycle
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      ack     <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      ack     <= accept;
      valid_q <= accept && legal;  // same cycle as ack
    end
  end

  // payload, only meaningful while valid_q is high
  always_ff @(posedge clock) begin
    if (accept) begin
      op_q    <= req_op;
      line_q  <= adr[bp_bus_pkg::adr_line_lsb +: bp_cfg_pkg::bp_line_w];
      slot_q  <= adr[bp_bus_pkg::adr_slot_lsb +: bp_cfg_pkg::bp_slot_w];
      taken_q <= dat_w[0];  // resolve outcome
    end
  end

  assign cmd = '{valid: valid_q,
                 op:    op_q,
                 line:  line_q,
                 slot:  slot_q,
                 taken: taken_q};

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# compile and run the branch predictor regression with verilator
# exit status is nonzero when the build, the run or the regression fails

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary -Wno-fatal --top-module bp_tb -f filelist.f -Mdir "$obj" -o bp_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit 1
fi

"./$obj/bp_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the log decides pass or fail
if grep -q "Regression failed" "$log"; then
  exit 1
fi
if ! grep -q "Regression passed" "$log"; then
  echo "no result line found in $log"
  exit 1
fi

exit 0

//--- tb/bp_model.svh
// ----------------------------------------------------------------------
// reference model of counter table and statistics, lcg, compare tasks
// ----------------------------------------------------------------------
`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH

// model counters as plain ints, 0 = strong not taken .. 3 = strong taken
int                    model_ctr [bp_cfg_pkg::bp_lines][bp_cfg_pkg::bp_slots];
bp_bus_pkg::bp_stats_t model_stats;
int unsigned           lcg_state = 32'd91684;  // fixed seed
int                    checks = 0;
int                    errors = 0;

// table and counts back to the post-reset state
function automatic void model_clear();
  for (int l = 0; l < bp_cfg_pkg::bp_lines; l++) begin
    for (int s = 0; s < bp_cfg_pkg::bp_slots; s++) begin
      model_ctr[l][s] = int'(bp_cfg_pkg::weak_nt);
    end
  end
  model_stats = '0;
endfunction

// taken when the counter sits in its upper half
function automatic bp_bus_pkg::bp_pred_t model_pred(input logic [1:0] line);
  bp_bus_pkg::bp_pred_t p;
  for (int s = 0; s < bp_cfg_pkg::bp_slots; s++) begin
    p.taken[s] = (model_ctr[line][s] >= int'(bp_cfg_pkg::weak_t));
  end
  return p;
endfunction

function automatic void model_resolve(input logic [1:0] line, input logic [1:0] slot,
                                      input logic taken);
  int   c;
  logic was_taken;
  c = model_ctr[line][slot];
  was_taken = (c >= int'(bp_cfg_pkg::weak_t));
  model_stats.resolves = model_stats.resolves + 1'b1;  // wraps at 16 bits
  if (was_taken != taken) begin
    model_stats.mispredicts = model_stats.mispredicts + 1'b1;
  end
  // saturate at both ends
  if (taken && c < int'(bp_cfg_pkg::strong_t)) begin
    c = c + 1;
  end else if (!taken && c > int'(bp_cfg_pkg::strong_nt)) begin
    c = c - 1;
  end
  model_ctr[line][slot] = c;
endfunction

// lcg, upper bits only since the low ones cycle fast
function automatic int unsigned lcg_next();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state >> 16;
endfunction

task automatic check_pred(input string sig, input bp_bus_pkg::bp_pred_t got,
                          input bp_bus_pkg::bp_pred_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("[FAIL] t=%0t %s got %b expected %b", $time, sig, got.taken, exp.taken);
  end
endtask

task automatic check_stats(input string sig, input bp_bus_pkg::bp_stats_t got,
                           input bp_bus_pkg::bp_stats_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("[FAIL] t=%0t %s got %h expected %h", $time, sig, got, exp);
  end
endtask

`endif

//--- tb/bp_tb.sv
// ----------------------------------------------------------------------
// bp_top testbench with wishbone driver and clock and reset
// directed table and random phase checked against the model
// ----------------------------------------------------------------------
`default_nettype none

module bp_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int n_random = 200;
  localparam int n_tests  = 6;

  logic                            clock;
  logic                            rst_n;
  logic                            cyc;
  logic                            stb;
  logic                            we;
  logic [bp_bus_pkg::wb_adr_w-1:0] adr;
  logic [bp_bus_pkg::wb_dat_w-1:0] dat_w;
  logic                            ack;
  logic [bp_bus_pkg::wb_dat_w-1:0] dat_r;

  `include "bp_model.svh"

  // one row of the directed table
  typedef struct {
    int                 test_id;
    bp_bus_pkg::bp_op_e op;
    logic [1:0]         line;
    logic [1:0]         slot;
    logic               taken;
    logic [31:0]        exp_val;  // expected prediction or stats word
  } step_t;

  step_t dir_q [$];
  string test_name [1:n_tests];
  int    tests_passed = 0;
  int    cycles = 0;
  int    cycle_limit = 50;

  bp_top uut (
    .clock (clock),
    .rst_n (rst_n),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .ack   (ack),
    .dat_r (dat_r)
  );

  initial clock = 1'b0;
  always #20 clock = ~clock;  // 40 ns period

  // watchdog
  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the bus never finished", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic add_step(input int id, input bp_bus_pkg::bp_op_e op, input logic [1:0] line,
                          input logic [1:0] slot, input logic taken, input logic [31:0] exp_val);
    step_t st;
    st.test_id = id;
    st.op      = op;
    st.line    = line;
    st.slot    = slot;
    st.taken   = taken;
    st.exp_val = exp_val;
    dir_q.push_back(st);
  endtask

  // one classic cycle held until ack then an idle cycle
  task automatic bus_xfer(input bp_bus_pkg::bp_op_e op, input logic [1:0] line,
                          input logic [1:0] slot, input logic taken, output logic [31:0] rdata);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = (op == bp_bus_pkg::op_resolve) || (op == bp_bus_pkg::op_clear);
    adr   = {op, line, slot};
    dat_w = {31'd0, taken};  // outcome in bit 0
    do begin
      @(posedge clock);
      #2;
    end while (!ack);
    rdata = dat_r;  // valid only in the ack cycle
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat_w = '0;
    @(posedge clock);
    #2;
  endtask

  // one op with read checks and a model update on writes
  task automatic run_op(input bp_bus_pkg::bp_op_e op, input logic [1:0] line,
                        input logic [1:0] slot, input logic taken, input logic [31:0] exp_val);
    logic [31:0] rdata;
    bus_xfer(op, line, slot, taken, rdata);
    if ((op == bp_bus_pkg::op_resolve || op == bp_bus_pkg::op_clear) && rdata !== '0) begin
      errors++;
      $display("[FAIL] t=%0t dat_r on write got %h expected 0", $time, rdata);
    end
    case (op)
      bp_bus_pkg::op_predict: begin
        check_pred($sformatf("dat_r predict line %0d", line),
                   bp_bus_pkg::bp_pred_t'(rdata[3:0]), bp_bus_pkg::bp_pred_t'(exp_val[3:0]));
        if (rdata[31:4] != '0) begin
          errors++;
          $display("[FAIL] t=%0t dat_r[31:4] got %h expected 0", $time, rdata[31:4]);
        end
      end
      bp_bus_pkg::op_stats: check_stats("dat_r stats", bp_bus_pkg::bp_stats_t'(rdata),
                                        bp_bus_pkg::bp_stats_t'(exp_val));
      bp_bus_pkg::op_resolve: model_resolve(line, slot, taken);
      default: model_clear();
    endcase
  endtask

  task automatic report_test(input int id, input int errs_before);
    if (errors == errs_before) begin
      tests_passed++;
      $display("test %0d %s ok", id, test_name[id]);
    end else begin
      $display("test %0d %s FAIL, %0d errors", id, test_name[id], errors - errs_before);
    end
  endtask

  initial begin
    int unsigned        r;
    bp_bus_pkg::bp_op_e op;
    logic [1:0]         line;
    logic [1:0]         slot;
    logic               taken;
    logic [31:0]        exp_val;
    int                 start_errs;

    // dut inputs idle while reset is held
    rst_n = 1'b0;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat_w = '0;
    model_clear();

    test_name[1] = "reset state";
    test_name[2] = "train one slot";
    test_name[3] = "saturation";
    test_name[4] = "statistics";
    test_name[5] = "clear";
    test_name[6] = "random mixed";

    // test 1 expects every slot weak not taken and zero stats
    add_step(1, bp_bus_pkg::op_predict, 2'd0, 2'd0, 1'b0, 32'h0);
    add_step(1, bp_bus_pkg::op_predict, 2'd1, 2'd0, 1'b0, 32'h0);
    add_step(1, bp_bus_pkg::op_predict, 2'd2, 2'd0, 1'b0, 32'h0);
    add_step(1, bp_bus_pkg::op_predict, 2'd3, 2'd0, 1'b0, 32'h0);
    add_step(1, bp_bus_pkg::op_stats,   2'd0, 2'd0, 1'b0, 32'h0);
    // test 2 trains line 1 slot 2 taken and leaves its neighbours alone
    add_step(2, bp_bus_pkg::op_resolve, 2'd1, 2'd2, 1'b1, 32'h0);  // mispredict
    add_step(2, bp_bus_pkg::op_resolve, 2'd1, 2'd2, 1'b1, 32'h0);
    add_step(2, bp_bus_pkg::op_predict, 2'd1, 2'd0, 1'b0, 32'h4);
    add_step(2, bp_bus_pkg::op_predict, 2'd0, 2'd0, 1'b0, 32'h0);
    add_step(2, bp_bus_pkg::op_predict, 2'd2, 2'd0, 1'b0, 32'h0);
    // test 3 saturates line 3 slot 0 so one not taken leaves it weak taken
    add_step(3, bp_bus_pkg::op_resolve, 2'd3, 2'd0, 1'b1, 32'h0);  // mispredict
    add_step(3, bp_bus_pkg::op_resolve, 2'd3, 2'd0, 1'b1, 32'h0);
    add_step(3, bp_bus_pkg::op_resolve, 2'd3, 2'd0, 1'b1, 32'h0);
    add_step(3, bp_bus_pkg::op_resolve, 2'd3, 2'd0, 1'b1, 32'h0);
    add_step(3, bp_bus_pkg::op_resolve, 2'd3, 2'd0, 1'b1, 32'h0);
    add_step(3, bp_bus_pkg::op_resolve, 2'd3, 2'd0, 1'b0, 32'h0);  // mispredict
    add_step(3, bp_bus_pkg::op_predict, 2'd3, 2'd0, 1'b0, 32'h1);
    // line 2 slot 3 drops to strong not taken so one taken keeps it not taken
    add_step(3, bp_bus_pkg::op_resolve, 2'd2, 2'd3, 1'b0, 32'h0);
    add_step(3, bp_bus_pkg::op_resolve, 2'd2, 2'd3, 1'b0, 32'h0);
    add_step(3, bp_bus_pkg::op_resolve, 2'd2, 2'd3, 1'b0, 32'h0);
    add_step(3, bp_bus_pkg::op_predict, 2'd2, 2'd0, 1'b0, 32'h0);
    add_step(3, bp_bus_pkg::op_resolve, 2'd2, 2'd3, 1'b1, 32'h0);  // mispredict
    add_step(3, bp_bus_pkg::op_predict, 2'd2, 2'd0, 1'b0, 32'h0);
    // test 4 starts from 12 resolves and 4 mispredicts
    add_step(4, bp_bus_pkg::op_stats,   2'd0, 2'd0, 1'b0, 32'h0004_000c);
    add_step(4, bp_bus_pkg::op_resolve, 2'd0, 2'd1, 1'b0, 32'h0);
    add_step(4, bp_bus_pkg::op_resolve, 2'd0, 2'd1, 1'b1, 32'h0);  // mispredict
    add_step(4, bp_bus_pkg::op_stats,   2'd0, 2'd0, 1'b0, 32'h0005_000e);
    add_step(4, bp_bus_pkg::op_predict, 2'd0, 2'd0, 1'b0, 32'h0);
    // test 5 clears and then a single taken flips a slot again
    add_step(5, bp_bus_pkg::op_clear,   2'd0, 2'd0, 1'b0, 32'h0);
    add_step(5, bp_bus_pkg::op_predict, 2'd0, 2'd0, 1'b0, 32'h0);
    add_step(5, bp_bus_pkg::op_predict, 2'd1, 2'd0, 1'b0, 32'h0);
    add_step(5, bp_bus_pkg::op_predict, 2'd2, 2'd0, 1'b0, 32'h0);
    add_step(5, bp_bus_pkg::op_predict, 2'd3, 2'd0, 1'b0, 32'h0);
    add_step(5, bp_bus_pkg::op_stats,   2'd0, 2'd0, 1'b0, 32'h0);
    add_step(5, bp_bus_pkg::op_resolve, 2'd1, 2'd2, 1'b1, 32'h0);  // mispredict
    add_step(5, bp_bus_pkg::op_predict, 2'd1, 2'd0, 1'b0, 32'h4);
    add_step(5, bp_bus_pkg::op_stats,   2'd0, 2'd0, 1'b0, 32'h0001_0001);

    cycle_limit = 4 * (dir_q.size() + n_random) + 50;

    repeat (5) @(posedge clock);
    #2;
    rst_n = 1'b1;
    start_errs = errors;
    if (ack !== 1'b0) begin
      errors++;
      $display("[FAIL] t=%0t ack got %b expected 0", $time, ack);
    end
    if (dat_r !== '0) begin
      errors++;
      $display("[FAIL] t=%0t dat_r got %h expected 0", $time, dat_r);
    end

    // directed table with one report line per test id
    for (int i = 0; i < dir_q.size(); i++) begin
      run_op(dir_q[i].op, dir_q[i].line, dir_q[i].slot, dir_q[i].taken, dir_q[i].exp_val);
      if (i == dir_q.size() - 1 || dir_q[i + 1].test_id != dir_q[i].test_id) begin
        report_test(dir_q[i].test_id, start_errs);
        start_errs = errors;
      end
    end

    // random mix with clear kept rare
    for (int i = 0; i < n_random; i++) begin
      r     = lcg_next();
      line  = r[5:4];
      slot  = r[7:6];
      taken = r[8];
      if (r[3:0] == 4'd0) begin
        op = bp_bus_pkg::op_clear;
      end else if (r[3:0] < 4'd6) begin
        op = bp_bus_pkg::op_predict;
      end else if (r[3:0] < 4'd9) begin
        op = bp_bus_pkg::op_stats;
      end else begin
        op = bp_bus_pkg::op_resolve;
      end
      exp_val = '0;
      if (op == bp_bus_pkg::op_predict) begin
        exp_val = {28'd0, model_pred(line)};
      end else if (op == bp_bus_pkg::op_stats) begin
        exp_val = model_stats;
      end
      run_op(op, line, slot, taken, exp_val);
    end
    report_test(6, start_errs);

    $display("tests passed %0d of %0d, checks %0d, errors %0d",
             tests_passed, n_tests, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
